// ==== hw/mcr_input_pkg.sv ====
package mcr_input_pkg;

	//====================================================================
	// Widths
	//====================================================================
	typedef logic [7:0]  port_byte_t;
	typedef logic [9:0]  ctrl_word_t;
	typedef logic [15:0] joy_word_t;
	// Bit 10 toggles per event, bit 9 is pressed, bits 7..0 scan code
	typedef logic [10:0] ps2_event_t;
	typedef logic [24:0] cfg_addr_t;

	// Game selection, any unknown code falls to GAME_NONE
	typedef enum logic [2:0] {
		GAME_RAMPAGE    = 3'd0,
		GAME_SARGE      = 3'd1,
		GAME_POWERDRIVE = 3'd2,
		GAME_MAXRPM     = 3'd3,
		GAME_NONE       = 3'd7
	} game_t;

	//====================================================================
	// Control bits, same order as the joystick word
	//====================================================================
	localparam int CTRL_RIGHT  = 0;
	localparam int CTRL_LEFT   = 1;
	localparam int CTRL_DOWN   = 2;
	localparam int CTRL_UP     = 3;
	localparam int CTRL_FIRE_A = 4;
	localparam int CTRL_FIRE_B = 5;
	localparam int CTRL_FIRE_C = 6;
	localparam int CTRL_FIRE_D = 7;
	localparam int CTRL_START  = 8;
	localparam int CTRL_COIN   = 9;

	// Configuration write indices
	localparam logic [7:0] CFG_INDEX_GAME = 8'd1;
	localparam logic [7:0] CFG_INDEX_DIP  = 8'd254;

	localparam port_byte_t PORT_IDLE = '1;

endpackage

// ==== hw/game_config.sv ====
`timescale 1ns/1ps

module game_config #(
	parameter int DIP_COUNT = 2
) (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     cfg_wr,
	input  logic [7:0]               cfg_index,
	input  mcr_input_pkg::cfg_addr_t  cfg_addr,
	input  mcr_input_pkg::port_byte_t cfg_data,
	output mcr_input_pkg::game_t      game,
	output mcr_input_pkg::port_byte_t dip0,
	output mcr_input_pkg::port_byte_t dip1
);
	import mcr_input_pkg::*;

	localparam int DIP_IDX_W = $clog2(DIP_COUNT);

	port_byte_t game_code;
	port_byte_t dip_reg [DIP_COUNT];

	// Game byte first, enum decode one clock later
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			game_code <= '0;
			game <= GAME_RAMPAGE;
		end else begin
			if (cfg_wr && cfg_index == CFG_INDEX_GAME)
				game_code <= cfg_data;
			case (game_code)
				8'd0: game <= GAME_RAMPAGE;
				8'd1: game <= GAME_SARGE;
				8'd2: game <= GAME_POWERDRIVE;
				8'd3: game <= GAME_MAXRPM;
				default: game <= GAME_NONE;
			endcase
		end
	end

	// DIP bytes, address must fall inside the table
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			for (int i = 0; i < DIP_COUNT; i++)
				dip_reg[i] <= '0;
		end else if (cfg_wr && cfg_index == CFG_INDEX_DIP &&
				cfg_addr < cfg_addr_t'(DIP_COUNT)) begin
			dip_reg[cfg_addr[DIP_IDX_W-1:0]] <= cfg_data;
		end
	end

	assign dip0 = dip_reg[0];
	assign dip1 = dip_reg[1];

endmodule

// ==== hw/key_decode.sv ====
`timescale 1ns/1ps

module key_decode (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  mcr_input_pkg::ps2_event_t ps2_key,
	output mcr_input_pkg::ctrl_word_t kb1,
	output mcr_input_pkg::ctrl_word_t kb2,
	output logic                      kb_coin2,
	output logic                      kb_coin3
);
	import mcr_input_pkg::*;

	logic       toggle_q;
	logic       key_event;
	logic       pressed;
	logic [7:0] code;

	assign pressed = ps2_key[9];
	assign code = ps2_key[7:0];
	assign key_event = ps2_key[10] != toggle_q;

	// Registered copy of the event toggle bit
	always_ff @(posedge clk_sys) begin
		toggle_q <= ps2_key[10];
	end

	//====================================================================
	// Scan code table
	//====================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			kb1 <= '0;
			kb2 <= '0;
			kb_coin2 <= 1'b0;
			kb_coin3 <= 1'b0;
		end else if (key_event) begin
			case (code)
				// Player 1 arrows and modifier keys
				8'h75: kb1[CTRL_UP] <= pressed;
				8'h72: kb1[CTRL_DOWN] <= pressed;
				8'h6B: kb1[CTRL_LEFT] <= pressed;
				8'h74: kb1[CTRL_RIGHT] <= pressed;
				8'h14: kb1[CTRL_FIRE_A] <= pressed;
				8'h11: kb1[CTRL_FIRE_B] <= pressed;
				8'h29: kb1[CTRL_FIRE_C] <= pressed;
				8'h12: kb1[CTRL_FIRE_D] <= pressed;
				8'h05: kb1[CTRL_START] <= pressed;
				8'h16: kb1[CTRL_START] <= pressed;
				8'h76: kb1[CTRL_COIN] <= pressed;
				8'h2E: kb1[CTRL_COIN] <= pressed;
				// Player 2 on the letter block
				8'h2D: kb2[CTRL_UP] <= pressed;
				8'h2B: kb2[CTRL_DOWN] <= pressed;
				8'h23: kb2[CTRL_LEFT] <= pressed;
				8'h34: kb2[CTRL_RIGHT] <= pressed;
				8'h1C: kb2[CTRL_FIRE_A] <= pressed;
				8'h1B: kb2[CTRL_FIRE_B] <= pressed;
				8'h21: kb2[CTRL_FIRE_C] <= pressed;
				8'h1D: kb2[CTRL_FIRE_D] <= pressed;
				8'h06: kb2[CTRL_START] <= pressed;
				8'h1E: kb2[CTRL_START] <= pressed;
				// Extra coin slots, keys 6 and 7
				8'h36: kb_coin2 <= pressed;
				8'h3D: kb_coin3 <= pressed;
				default: ;
			endcase
		end
	end

endmodule

// ==== hw/control_merge.sv ====
`timescale 1ns/1ps

module control_merge (
	input  mcr_input_pkg::game_t      game,
	input  mcr_input_pkg::ctrl_word_t kb1,
	input  mcr_input_pkg::ctrl_word_t kb2,
	input  logic                      kb_coin2,
	input  logic                      kb_coin3,
	input  mcr_input_pkg::joy_word_t  joy1,
	input  mcr_input_pkg::joy_word_t  joy2,
	input  mcr_input_pkg::joy_word_t  joy3,
	input  mcr_input_pkg::joy_word_t  joy4,
	output mcr_input_pkg::ctrl_word_t p1,
	output mcr_input_pkg::ctrl_word_t p2,
	output mcr_input_pkg::ctrl_word_t p3,
	output mcr_input_pkg::ctrl_word_t p4
);
	import mcr_input_pkg::*;

	always_comb begin
		// Keyboard only covers players 1 and 2
		p1 = kb1 | joy1[9:0];
		p2 = kb2 | joy2[9:0];
		p3 = joy3[9:0];
		p4 = joy4[9:0];

		if (game == GAME_POWERDRIVE) begin
			// One coin slot per player
			p2[CTRL_COIN] = kb_coin2 | joy2[CTRL_COIN];
		end else begin
			// Every coin goes into slot 1
			p1[CTRL_COIN] = kb1[CTRL_COIN] | kb_coin2 | kb_coin3 |
				joy1[CTRL_COIN] | joy2[CTRL_COIN] |
				joy3[CTRL_COIN] | joy4[CTRL_COIN];
			p2[CTRL_COIN] = 1'b0;
			p3[CTRL_COIN] = 1'b0;
		end

		p4[CTRL_COIN] = 1'b0;
	end

endmodule

// ==== hw/gear_shift.sv ====
`timescale 1ns/1ps

module gear_shift #(
	parameter int MAXRPM_TOP_GEAR = 4
) (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  mcr_input_pkg::ctrl_word_t p1,
	input  mcr_input_pkg::ctrl_word_t p2,
	input  mcr_input_pkg::ctrl_word_t p3,
	output logic [2:0]                pd_gear,
	output logic [3:0]                rpm_code1,
	output logic [3:0]                rpm_code2
);
	import mcr_input_pkg::*;

	localparam int GEAR_W = $clog2(MAXRPM_TOP_GEAR + 1);

	typedef logic [GEAR_W-1:0] gear_t;

	// Max RPM gearbox encoding as read by the CPU
	function automatic logic [3:0] gear_code(input int g);
		case (g)
			1: gear_code = 4'h5;
			2: gear_code = 4'h6;
			3: gear_code = 4'h1;
			4: gear_code = 4'h2;
			default: gear_code = 4'h0;
		endcase
	endfunction

	// Start wins, then upshift, then downshift
	function automatic gear_t next_gear(input gear_t cur, input logic start,
			input logic up, input logic down);
		gear_t nxt;
		nxt = cur;
		if (start)
			nxt = '0;
		else if (up) begin
			if (cur != gear_t'(MAXRPM_TOP_GEAR))
				nxt = cur + 1'b1;
		end else if (down) begin
			if (cur != '0)
				nxt = cur - 1'b1;
		end
		return nxt;
	endfunction

	logic [3:0] code_table [MAXRPM_TOP_GEAR+1];
	logic [2:0] fire_d;
	logic [2:0] fire_d_q;
	logic [1:0] fire_a;
	logic [1:0] fire_a_q;
	logic [1:0] fire_b;
	logic [1:0] fire_b_q;
	gear_t      gear1;
	gear_t      gear2;

	for (genvar g = 0; g <= MAXRPM_TOP_GEAR; g++) begin : g_code
		assign code_table[g] = gear_code(g);
	end

	assign fire_d = {p3[CTRL_FIRE_D], p2[CTRL_FIRE_D], p1[CTRL_FIRE_D]};
	assign fire_a = {p2[CTRL_FIRE_A], p1[CTRL_FIRE_A]};
	assign fire_b = {p2[CTRL_FIRE_B], p1[CTRL_FIRE_B]};

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			fire_d_q <= '0;
			fire_a_q <= '0;
			fire_b_q <= '0;
			pd_gear <= '0;
			gear1 <= '0;
			gear2 <= '0;
		end else begin
			fire_d_q <= fire_d;
			fire_a_q <= fire_a;
			fire_b_q <= fire_b;
			// Power Drive high/low toggle per player
			pd_gear <= pd_gear ^ (fire_d & ~fire_d_q);
			gear1 <= next_gear(gear1, p1[CTRL_START],
				fire_a[0] & ~fire_a_q[0], fire_b[0] & ~fire_b_q[0]);
			gear2 <= next_gear(gear2, p2[CTRL_START],
				fire_a[1] & ~fire_a_q[1], fire_b[1] & ~fire_b_q[1]);
		end
	end

	assign rpm_code1 = code_table[gear1];
	assign rpm_code2 = code_table[gear2];

endmodule

// ==== hw/input_port_mux.sv ====
`timescale 1ns/1ps

module input_port_mux (
	input  mcr_input_pkg::game_t      game,
	input  mcr_input_pkg::port_byte_t dip0,
	input  mcr_input_pkg::port_byte_t dip1,
	input  mcr_input_pkg::ctrl_word_t p1,
	input  mcr_input_pkg::ctrl_word_t p2,
	input  mcr_input_pkg::ctrl_word_t p3,
	input  logic [2:0]                pd_gear,
	input  logic [3:0]                rpm_code1,
	input  logic [3:0]                rpm_code2,
	input  logic                      stick_mode,
	input  logic                      snd_stat,
	output mcr_input_pkg::port_byte_t in0,
	output mcr_input_pkg::port_byte_t in1,
	output mcr_input_pkg::port_byte_t in2,
	output mcr_input_pkg::port_byte_t in3,
	output mcr_input_pkg::port_byte_t in4
);
	import mcr_input_pkg::*;

	// Rampage joystick byte, low six bits
	function automatic logic [5:0] ramp_bits(input ctrl_word_t p);
		return {p[CTRL_FIRE_B], p[CTRL_FIRE_A], p[CTRL_LEFT],
			p[CTRL_DOWN], p[CTRL_RIGHT], p[CTRL_UP]};
	endfunction

	// Sarge two-stick remap, returns rd, ru, ld, lu
	function automatic logic [3:0] stick_bits(input ctrl_word_t p, input logic mode);
		logic lu;
		logic ld;
		logic ru;
		logic rd;
		if (mode) begin
			// Diagonals of one stick drive both tank treads
			lu = p[CTRL_UP] | p[CTRL_RIGHT];
			ld = p[CTRL_DOWN] | p[CTRL_LEFT];
			ru = p[CTRL_UP] | p[CTRL_LEFT];
			rd = p[CTRL_DOWN] | p[CTRL_RIGHT];
		end else begin
			lu = p[CTRL_UP];
			ld = p[CTRL_DOWN];
			ru = p[CTRL_FIRE_C];
			rd = p[CTRL_FIRE_B];
		end
		return {rd, ru, ld, lu};
	endfunction

	//====================================================================
	// Per-game port layout, all ports active low
	//====================================================================
	always_comb begin
		in0 = PORT_IDLE;
		in1 = PORT_IDLE;
		in2 = PORT_IDLE;
		in3 = dip0;
		in4 = PORT_IDLE;

		case (game)
			GAME_RAMPAGE: begin
				in0 = ~{2'b00, dip1[0], 3'b000, p2[CTRL_COIN], p1[CTRL_COIN]};
				in1 = ~{2'b00, ramp_bits(p1)};
				in2 = ~{2'b00, ramp_bits(p2)};
				in4 = ~{snd_stat, 1'b0, ramp_bits(p3)};
			end
			GAME_SARGE: begin
				in0 = ~{2'b00, dip1[0], 1'b0, p2[CTRL_START], p1[CTRL_START],
					p2[CTRL_COIN], p1[CTRL_COIN]};
				in1 = ~{p1[CTRL_FIRE_D], p1[CTRL_FIRE_D], p1[CTRL_FIRE_A],
					p1[CTRL_FIRE_A], stick_bits(p1, stick_mode)};
				in2 = ~{p2[CTRL_FIRE_D], p2[CTRL_FIRE_D], p2[CTRL_FIRE_A],
					p2[CTRL_FIRE_A], stick_bits(p2, stick_mode)};
			end
			GAME_POWERDRIVE: begin
				in0 = ~{2'b00, dip1[0], 2'b00, p3[CTRL_COIN], p2[CTRL_COIN],
					p1[CTRL_COIN]};
				in1 = ~{p2[CTRL_FIRE_B], p2[CTRL_FIRE_A], pd_gear[1], p2[CTRL_FIRE_C],
					p1[CTRL_FIRE_B], p1[CTRL_FIRE_A], pd_gear[0], p1[CTRL_FIRE_C]};
				in2 = ~{snd_stat, 3'b000, p3[CTRL_FIRE_B], p3[CTRL_FIRE_A],
					pd_gear[2], p3[CTRL_FIRE_C]};
			end
			GAME_MAXRPM: begin
				in0 = ~{dip1[0], 3'b000, p1[CTRL_START], p2[CTRL_START],
					p1[CTRL_COIN], p2[CTRL_COIN]};
				// Pedal and steering port not built, reads idle
				in1 = PORT_IDLE;
				in2 = ~{rpm_code1, rpm_code2};
			end
			default: ;
		endcase
	end

endmodule

// ==== hw/mcr_input_top.sv ====
`timescale 1ns/1ps

module mcr_input_top #(
	parameter int DIP_COUNT       = 2,
	parameter int MAXRPM_TOP_GEAR = 4
) (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      cfg_wr,
	input  logic [7:0]                cfg_index,
	input  mcr_input_pkg::cfg_addr_t  cfg_addr,
	input  mcr_input_pkg::port_byte_t cfg_data,
	input  mcr_input_pkg::ps2_event_t ps2_key,
	input  mcr_input_pkg::joy_word_t  joy1,
	input  mcr_input_pkg::joy_word_t  joy2,
	input  mcr_input_pkg::joy_word_t  joy3,
	input  mcr_input_pkg::joy_word_t  joy4,
	input  logic                      stick_mode,
	input  logic                      snd_stat,
	output mcr_input_pkg::port_byte_t in0,
	output mcr_input_pkg::port_byte_t in1,
	output mcr_input_pkg::port_byte_t in2,
	output mcr_input_pkg::port_byte_t in3,
	output mcr_input_pkg::port_byte_t in4
);
	import mcr_input_pkg::*;

	game_t      game;
	port_byte_t dip0;
	port_byte_t dip1;
	ctrl_word_t kb1;
	ctrl_word_t kb2;
	logic       kb_coin2;
	logic       kb_coin3;
	ctrl_word_t p1;
	ctrl_word_t p2;
	ctrl_word_t p3;
	logic [2:0] pd_gear;
	logic [3:0] rpm_code1;
	logic [3:0] rpm_code2;

	//====================================================================
	// Stage chain: config, keyboard, merge, gears, port layout
	//====================================================================
	game_config #(.DIP_COUNT(DIP_COUNT)) config0 (
		.clk_sys(clk_sys), .reset(reset), .cfg_wr(cfg_wr), .cfg_index(cfg_index),
		.cfg_addr(cfg_addr), .cfg_data(cfg_data),
		.game(game), .dip0(dip0), .dip1(dip1)
	);

	key_decode keys0 (
		.clk_sys(clk_sys), .reset(reset), .ps2_key(ps2_key),
		.kb1(kb1), .kb2(kb2), .kb_coin2(kb_coin2), .kb_coin3(kb_coin3)
	);

	// Player 4 has no consumer among the kept games
	control_merge merge0 (
		.game(game), .kb1(kb1), .kb2(kb2), .kb_coin2(kb_coin2), .kb_coin3(kb_coin3),
		.joy1(joy1), .joy2(joy2), .joy3(joy3), .joy4(joy4),
		.p1(p1), .p2(p2), .p3(p3), .p4()
	);

	gear_shift #(.MAXRPM_TOP_GEAR(MAXRPM_TOP_GEAR)) gears0 (
		.clk_sys(clk_sys), .reset(reset), .p1(p1), .p2(p2), .p3(p3),
		.pd_gear(pd_gear), .rpm_code1(rpm_code1), .rpm_code2(rpm_code2)
	);

	input_port_mux ports0 (
		.game(game), .dip0(dip0), .dip1(dip1), .p1(p1), .p2(p2), .p3(p3),
		.pd_gear(pd_gear), .rpm_code1(rpm_code1), .rpm_code2(rpm_code2),
		.stick_mode(stick_mode), .snd_stat(snd_stat),
		.in0(in0), .in1(in1), .in2(in2), .in3(in3), .in4(in4)
	);

endmodule

// ==== testbench/tb_mcr_input.sv ====
`timescale 1ns/1ps

module tb_mcr_input;
	import mcr_input_pkg::*;

	logic        clk_sys;
	logic        reset;
	logic        cfg_wr;
	logic [7:0]  cfg_index;
	cfg_addr_t   cfg_addr;
	port_byte_t  cfg_data;
	ps2_event_t  ps2_key;
	joy_word_t   joy1;
	joy_word_t   joy2;
	joy_word_t   joy3;
	joy_word_t   joy4;
	logic        stick_mode;
	logic        snd_stat;
	port_byte_t  in0;
	port_byte_t  in1;
	port_byte_t  in2;
	port_byte_t  in3;
	port_byte_t  in4;

	int          errors;
	int          checks;
	int          cycles;
	int          gear [2];
	logic [2:0]  pd_model;
	port_byte_t  dip1_val;

	mcr_input_top #(.DIP_COUNT(2), .MAXRPM_TOP_GEAR(4)) dut0 (
		.clk_sys(clk_sys), .reset(reset), .cfg_wr(cfg_wr), .cfg_index(cfg_index),
		.cfg_addr(cfg_addr), .cfg_data(cfg_data), .ps2_key(ps2_key),
		.joy1(joy1), .joy2(joy2), .joy3(joy3), .joy4(joy4),
		.stick_mode(stick_mode), .snd_stat(snd_stat),
		.in0(in0), .in1(in1), .in2(in2), .in3(in3), .in4(in4)
	);

	always #10 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles = cycles + 1;
		if (cycles >= 4000) begin
			$display("Timeout: the run did not finish within 4000 clock cycles");
			$display("Simulation FAILED");
			$finish;
		end
	end

	//======================================================================
	// Expected port bytes
	//======================================================================
	function automatic port_byte_t ramp_port(input ctrl_word_t p);
		return ~{2'b00, p[CTRL_FIRE_B], p[CTRL_FIRE_A], p[CTRL_LEFT],
			p[CTRL_DOWN], p[CTRL_RIGHT], p[CTRL_UP]};
	endfunction

	function automatic port_byte_t sarge_port(input ctrl_word_t p, input logic mode);
		logic [3:0] stick;
		// Order is rd, ru, ld, lu
		if (mode)
			stick = {p[CTRL_DOWN] | p[CTRL_RIGHT], p[CTRL_UP] | p[CTRL_LEFT],
				p[CTRL_DOWN] | p[CTRL_LEFT], p[CTRL_UP] | p[CTRL_RIGHT]};
		else
			stick = {p[CTRL_FIRE_B], p[CTRL_FIRE_C], p[CTRL_DOWN], p[CTRL_UP]};
		return ~{p[CTRL_FIRE_D], p[CTRL_FIRE_D], p[CTRL_FIRE_A], p[CTRL_FIRE_A], stick};
	endfunction

	function automatic logic [3:0] rpm_code(input int g);
		case (g)
			1: return 4'h5;
			2: return 4'h6;
			3: return 4'h1;
			4: return 4'h2;
			default: return 4'h0;
		endcase
	endfunction

	task automatic check_port(input string name, input port_byte_t got, input port_byte_t exp);
		checks++;
		assert (got === exp)
		else begin
			errors++;
			$display("Fail at %0t ns: %s read %h, expected %h", $time, name, got, exp);
		end
	endtask

	// All tasks start and end on a falling edge
	task automatic cfg_write(input logic [7:0] index, input int addr, input port_byte_t data);
		cfg_wr = 1'b1;
		cfg_index = index;
		cfg_addr = cfg_addr_t'(addr);
		cfg_data = data;
		@(negedge clk_sys);
		cfg_wr = 1'b0;
	endtask

	task automatic select_game(input port_byte_t code);
		cfg_write(CFG_INDEX_GAME, 0, code);
		@(negedge clk_sys);
	endtask

	task automatic send_key(input logic [7:0] code, input logic pressed);
		ps2_key = {~ps2_key[10], pressed, 1'b0, code};
		@(negedge clk_sys);
	endtask

	task automatic shift_gear(input int pl, input int bitpos);
		if (pl == 0)
			joy1[bitpos] = 1'b1;
		else
			joy2[bitpos] = 1'b1;
		@(negedge clk_sys);
		if (bitpos == CTRL_START)
			gear[pl] = 0;
		else if (bitpos == CTRL_FIRE_A && gear[pl] < 4)
			gear[pl]++;
		else if (bitpos == CTRL_FIRE_B && gear[pl] > 0)
			gear[pl]--;
		check_port("in2", in2, ~{rpm_code(gear[0]), rpm_code(gear[1])});
		joy1 = '0;
		joy2 = '0;
		@(negedge clk_sys);
	endtask

	initial begin
		clk_sys = 1'b0;
		reset = 1'b1;
		cfg_wr = 1'b0;
		cfg_index = '0;
		cfg_addr = '0;
		cfg_data = '0;
		ps2_key = '0;
		joy1 = '0;
		joy2 = '0;
		joy3 = '0;
		joy4 = '0;
		stick_mode = 1'b0;
		snd_stat = 1'b0;
		errors = 0;
		checks = 0;
		cycles = 0;
		gear[0] = 0;
		gear[1] = 0;
		pd_model = '0;
		void'($urandom(32'h0b48a462));
		repeat (5) @(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);

		// Idle Rampage after reset
		check_port("in0", in0, 8'hFF);
		check_port("in1", in1, 8'hFF);
		check_port("in2", in2, 8'hFF);
		check_port("in3", in3, 8'h00);
		check_port("in4", in4, 8'hFF);
		snd_stat = 1'b1;
		@(negedge clk_sys);
		check_port("in4", in4, 8'h7F);
		snd_stat = 1'b0;

		//==================================================================
		// Keyboard and joystick merge
		//==================================================================
		send_key(8'h75, 1'b1);
		check_port("in1", in1, 8'hFE);
		for (int i = 0; i < 8; i++) begin
			// Fire D stays off so the Power Drive gears keep their reset value
			joy1 = $urandom & 16'hFF7F;
			joy2 = $urandom & 16'hFF7F;
			@(negedge clk_sys);
			check_port("in1", in1, ramp_port(joy1[9:0] | 10'h008));
			check_port("in2", in2, ramp_port(joy2[9:0]));
		end
		joy1 = '0;
		joy2 = '0;
		send_key(8'h75, 1'b0);
		check_port("in1", in1, 8'hFF);

		// Coin routing and DIP bytes
		joy2 = 16'h0200;
		@(negedge clk_sys);
		check_port("in0", in0, 8'hFE);
		cfg_write(CFG_INDEX_DIP, 0, 8'h5A);
		check_port("in3", in3, 8'h5A);
		dip1_val = $urandom;
		cfg_write(CFG_INDEX_DIP, 1, dip1_val);
		cfg_write(CFG_INDEX_GAME, 0, 8'd2);
		check_port("in0", in0, ~{2'b00, dip1_val[0], 5'b00001});
		@(negedge clk_sys);
		check_port("in0", in0, ~{2'b00, dip1_val[0], 5'b00010});
		joy2 = '0;

		// Power Drive toggles, each player twice
		for (int r = 0; r < 2; r++) begin
			for (int pl = 0; pl < 3; pl++) begin
				joy1[CTRL_FIRE_D] = (pl == 0);
				joy2[CTRL_FIRE_D] = (pl == 1);
				joy3[CTRL_FIRE_D] = (pl == 2);
				@(negedge clk_sys);
				pd_model[pl] = ~pd_model[pl];
				check_port("in1", in1, ~{2'b00, pd_model[1], 3'b000, pd_model[0], 1'b0});
				check_port("in2", in2, ~{6'b000000, pd_model[2], 1'b0});
				joy1 = '0;
				joy2 = '0;
				joy3 = '0;
				@(negedge clk_sys);
			end
		end

		//==================================================================
		// Max RPM gearbox
		//==================================================================
		select_game(8'd3);
		// Random fire bits above left both gears at unknown positions
		joy1[CTRL_START] = 1'b1;
		joy2[CTRL_START] = 1'b1;
		@(negedge clk_sys);
		joy1 = '0;
		joy2 = '0;
		@(negedge clk_sys);
		shift_gear(0, CTRL_START);
		shift_gear(1, CTRL_START);
		repeat (6) shift_gear(0, CTRL_FIRE_A);
		shift_gear(0, CTRL_START);
		repeat (2) shift_gear(1, CTRL_FIRE_B);
		for (int i = 0; i < 24; i++) begin
			int op;
			op = $urandom % 8;
			if (op < 4)
				shift_gear($urandom % 2, CTRL_FIRE_A);
			else if (op < 7)
				shift_gear($urandom % 2, CTRL_FIRE_B);
			else
				shift_gear($urandom % 2, CTRL_START);
		end

		// Sarge sticks in both modes
		select_game(8'd1);
		for (int mode = 0; mode < 2; mode++) begin
			stick_mode = mode[0];
			for (int i = 0; i < 10; i++) begin
				joy1 = $urandom;
				joy2 = $urandom;
				@(negedge clk_sys);
				check_port("in1", in1, sarge_port(joy1[9:0], stick_mode));
				check_port("in2", in2, sarge_port(joy2[9:0], stick_mode));
			end
		end

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== list.f ====
hw/mcr_input_pkg.sv
hw/game_config.sv
hw/key_decode.sv
hw/control_merge.sv
hw/gear_shift.sv
hw/input_port_mux.sv
hw/mcr_input_top.sv
testbench/tb_mcr_input.sv
